// File: include/stm_macros.svh
/*
 * STM engine sizing: transducers per point, table capacity,
 * drive word width and point FIFO depth
 */

`ifndef STM_MACROS_SVH
`define STM_MACROS_SVH

`default_nettype none

`define STM_NUM_TR      8   // transducers per point
`define STM_MAX_POINTS  16  // gain points held in the table
`define STM_WIDTH       13  // ultrasound period width
`define STM_FIFO_DEPTH  4   // also the initial credit count

`default_nettype wire

`endif

// File: rtl/stm_data_pkg.sv
/*
 * STM datapath types: host table writes, fetched table entries
 * and the drive words handed to the PWM stage
 */

`include "stm_macros.svh"

`default_nettype none

package stm_data_pkg;

    // host write port into the point table
    typedef struct packed {
        logic        en;
        logic [6:0]  addr;  // point * STM_NUM_TR + transducer
        logic [15:0] data;  // duty in upper byte, phase in lower
    } cpu_wr_t;

    // one table entry on its way to the gain operator
    typedef struct packed {
        logic [3:0] point;
        logic [2:0] tr;
        logic [7:0] duty8;
        logic [7:0] phase8;
        logic       first;
        logic       last;
    } stm_entry_t;

    // scaled word for one transducer
    typedef struct packed {
        logic [3:0]            point;
        logic [2:0]            tr;
        logic [`STM_WIDTH-1:0] duty;
        logic [`STM_WIDTH-1:0] phase;
        logic                  start;
        logic                  done;
    } drive_t;

endpackage

`default_nettype wire

// File: rtl/stm_ctrl_pkg.sv
/*
 * STM control encodings: fetch FSM states and gain entry formats
 */

`default_nettype none

package stm_ctrl_pkg;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_READ
    } fetch_state_e;

    // legacy tables carry half-scale duty
    typedef enum logic {
        FMT_FULL,
        FMT_LEGACY
    } gain_fmt_e;

endpackage

`default_nettype wire

// File: rtl/stm_fetch.sv
/*
 * STM fetcher: point table, tick sampler and credit-limited
 * read FSM pushing one entry per transducer into the point FIFO
 */

`include "stm_macros.svh"

`default_nettype none

module stm_fetch
    import stm_data_pkg::*, stm_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cpu_wr_t    cpu_wr,
    input  logic       stm_en,
    input  logic [3:0] cycle,
    input  logic [15:0] freq_div,
    input  logic       credit_ret,
    output stm_entry_t entry,
    output logic       entry_push,
    output logic [3:0] idx
);

    localparam int NUM_ENTRIES = `STM_MAX_POINTS * `STM_NUM_TR;
    localparam int CREDIT_W    = $clog2(`STM_FIFO_DEPTH + 1);

    logic [15:0]         table_mem [NUM_ENTRIES];
    logic [6:0]          rd_addr;
    logic [15:0]         rd_data;

    logic [15:0]         tick_cnt;
    logic                running;
    logic                adv;
    logic                req;
    logic [3:0]          idx_nxt;
    logic [3:0]          req_idx;

    fetch_state_e        state;
    logic [3:0]          cur_point;
    logic [2:0]          tr;
    logic                pending;
    logic [3:0]          pending_idx;
    logic [CREDIT_W-1:0] credits;

    always_ff @(posedge clk) begin
        if (cpu_wr.en) begin
            table_mem[cpu_wr.addr] <= cpu_wr.data;
        end
    end

    // sampler
    assign idx_nxt = (idx >= cycle) ? 4'd0 : idx + 4'd1;
    assign adv     = stm_en && (tick_cnt == freq_div - 16'd1);
    assign req     = stm_en && (!running || adv);
    assign req_idx = adv ? idx_nxt : idx;

    always_ff @(posedge clk) begin
        if (rst || !stm_en) begin
            tick_cnt <= '0;
            idx      <= '0;
            running  <= 1'b0;
        end else begin
            running <= 1'b1;
            if (adv) begin
                tick_cnt <= '0;
                idx      <= idx_nxt;
            end else begin
                tick_cnt <= tick_cnt + 16'd1;
            end
        end
    end

    // read FSM, one transducer per credit
    assign entry_push = (state == FETCH_READ) && (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= FETCH_IDLE;
            tr      <= '0;
            pending <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (req || pending) begin
                        state     <= FETCH_READ;
                        cur_point <= req ? req_idx : pending_idx;
                        tr        <= '0;
                        pending   <= 1'b0;
                    end
                end
                FETCH_READ: begin
                    if (req) begin  // newest point wins
                        pending     <= 1'b1;
                        pending_idx <= req_idx;
                    end
                    if (entry_push) begin
                        tr <= tr + 3'd1;
                        if (tr == 3'(`STM_NUM_TR - 1)) begin
                            state <= FETCH_IDLE;
                        end
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(`STM_FIFO_DEPTH);
        end else begin
            credits <= credits - CREDIT_W'(entry_push) + CREDIT_W'(credit_ret);
        end
    end

    assign rd_addr = 7'(cur_point * `STM_NUM_TR) + 7'(tr);
    assign rd_data = table_mem[rd_addr];

    always_comb begin
        entry.point  = cur_point;
        entry.tr     = tr;
        entry.duty8  = rd_data[15:8];
        entry.phase8 = rd_data[7:0];
        entry.first  = (tr == 3'd0);
        entry.last   = (tr == 3'(`STM_NUM_TR - 1));
    end

endmodule

`default_nettype wire

// File: rtl/stm_point_fifo.sv
/*
 * Point FIFO: circular store with a registered head entry,
 * sized so the fetcher's credits can never overrun it
 */

`include "stm_macros.svh"

`default_nettype none

module stm_point_fifo
    import stm_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  stm_entry_t entry,
    input  logic       push,
    input  logic       pop,
    output stm_entry_t head,
    output logic       head_valid
);

    localparam int PTR_W = $clog2(`STM_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`STM_FIFO_DEPTH + 1);

    stm_entry_t       mem [`STM_FIFO_DEPTH];
    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [CNT_W-1:0] count;  // entries behind the head
    logic             load;

    // refill head when empty or consumed
    assign load = (count != '0) && (!head_valid || pop);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr] <= entry;
        end
        if (load) begin
            head <= mem[rptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr       <= '0;
            rptr       <= '0;
            count      <= '0;
            head_valid <= 1'b0;
        end else begin
            if (push) begin
                wptr <= (wptr == PTR_W'(`STM_FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (load) begin
                rptr <= (rptr == PTR_W'(`STM_FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(load);
            if (load) begin
                head_valid <= 1'b1;
            end else if (pop) begin
                head_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/stm_gain_operator.sv
/*
 * STM gain operator: scales 8-bit duty and phase to the ultrasound
 * period and streams drive words with valid/ready handshake
 */

`include "stm_macros.svh"

`default_nettype none

module stm_gain_operator
    import stm_data_pkg::*, stm_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  stm_entry_t            head,
    input  logic                  head_valid,
    input  gain_fmt_e             fmt,
    input  logic [`STM_WIDTH-1:0] ult_cycle,
    input  logic                  drive_ready,
    output logic                  pop,
    output logic                  credit_ret,
    output drive_t                drive,
    output logic                  drive_valid
);

    localparam int W      = `STM_WIDTH;
    localparam int PROD_W = 8 + W;

    logic [PROD_W-1:0] duty_prod;
    logic [PROD_W-1:0] phase_prod;
    drive_t            drive_nxt;

    // take a new entry when the output slot is free or draining
    assign pop        = head_valid && (!drive_valid || drive_ready);
    assign credit_ret = pop;  // slot freed in the FIFO

    assign duty_prod  = head.duty8 * ult_cycle;
    assign phase_prod = head.phase8 * ult_cycle;

    always_comb begin
        drive_nxt.point = head.point;
        drive_nxt.tr    = head.tr;
        if (fmt == FMT_LEGACY) begin
            drive_nxt.duty = W'(duty_prod >> 9);
        end else begin
            drive_nxt.duty = W'(duty_prod >> 8);
        end
        drive_nxt.phase = W'(phase_prod >> 8);
        drive_nxt.start = head.first;
        drive_nxt.done  = head.last;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            drive_valid <= 1'b0;
        end else if (pop) begin
            drive_valid <= 1'b1;
        end else if (drive_ready) begin
            drive_valid <= 1'b0;
        end
    end

    // held while stalled
    always_ff @(posedge clk) begin
        if (pop) begin
            drive <= drive_nxt;
        end
    end

endmodule

`default_nettype wire

// File: rtl/stm_operator.sv
/*
 * STM gain path top: fetcher, point FIFO and gain operator
 * joined by credit flow control
 */

`include "stm_macros.svh"

`default_nettype none

module stm_operator
    import stm_data_pkg::*, stm_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_wr_t               cpu_wr,
    input  logic                  stm_en,
    input  logic [3:0]            cycle,
    input  logic [15:0]           freq_div,
    input  gain_fmt_e             fmt,
    input  logic [`STM_WIDTH-1:0] ult_cycle,
    input  logic                  drive_ready,
    output drive_t                drive,
    output logic                  drive_valid,
    output logic [3:0]            idx
);

    stm_entry_t entry;
    stm_entry_t head;
    logic       entry_push;
    logic       head_valid;
    logic       pop;
    logic       credit_ret;

    stm_fetch stm_fetch (
        .clk        (clk),
        .rst        (rst),
        .cpu_wr     (cpu_wr),
        .stm_en     (stm_en),
        .cycle      (cycle),
        .freq_div   (freq_div),
        .credit_ret (credit_ret),
        .entry      (entry),
        .entry_push (entry_push),
        .idx        (idx)
    );

    stm_point_fifo stm_point_fifo (
        .clk        (clk),
        .rst        (rst),
        .entry      (entry),
        .push       (entry_push),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid)
    );

    stm_gain_operator stm_gain_operator (
        .clk         (clk),
        .rst         (rst),
        .head        (head),
        .head_valid  (head_valid),
        .fmt         (fmt),
        .ult_cycle   (ult_cycle),
        .drive_ready (drive_ready),
        .pop         (pop),
        .credit_ret  (credit_ret),
        .drive       (drive),
        .drive_valid (drive_valid)
    );

endmodule

`default_nettype wire

// File: verification/stm_operator_properties.sv
/*
 * STM engine checks: credit bound, no push without credit,
 * drive word held while the consumer stalls
 */

`include "stm_macros.svh"

`default_nettype none

module stm_operator_properties
    import stm_data_pkg::*;
#(
    parameter int CREDIT_W = $clog2(`STM_FIFO_DEPTH + 1)
) (
    input logic                clk,
    input logic                rst,
    input logic [CREDIT_W-1:0] credits,
    input logic                entry_push,
    input logic                credit_ret,
    input drive_t              drive,
    input logic                drive_valid,
    input logic                drive_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [CREDIT_W-1:0] in_flight;  // pushed entries not yet handed back

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + CREDIT_W'(entry_push) - CREDIT_W'(credit_ret);
        end
    end

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CREDIT_W'(`STM_FIFO_DEPTH))
        else $error("credit count above FIFO depth");

    push_needs_credit: assert property (@(posedge clk) disable iff (rst)
        entry_push |-> in_flight < CREDIT_W'(`STM_FIFO_DEPTH))
        else $error("entry pushed with no credit left");

    // word must not change until taken
    drive_held: assert property (@(posedge clk) disable iff (rst)
        drive_valid && !drive_ready |=> drive_valid && $stable(drive))
        else $error("drive word changed while stalled");

endmodule

// fetch side, output checks tied off
bind stm_fetch stm_operator_properties i_fetch_properties (
    .clk         (clk),
    .rst         (rst),
    .credits     (credits),
    .entry_push  (entry_push),
    .credit_ret  (credit_ret),
    .drive       ('0),
    .drive_valid (1'b0),
    .drive_ready (1'b1)
);

// output side, credit checks tied off
bind stm_operator stm_operator_properties i_output_properties (
    .clk         (clk),
    .rst         (rst),
    .credits     ('0),
    .entry_push  (1'b0),
    .credit_ret  (1'b0),
    .drive       (drive),
    .drive_valid (drive_valid),
    .drive_ready (drive_ready)
);

`default_nettype wire

// File: verification/tb_stm_operator.sv
/*
 * STM gain path testbench: loads random tables, runs points with
 * and without back-pressure and checks every accepted drive word
 */

`include "stm_macros.svh"

`default_nettype none

module tb_stm_operator
    import stm_data_pkg::*, stm_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ENTRIES = `STM_MAX_POINTS * `STM_NUM_TR;
    localparam int NUM_TR      = `STM_NUM_TR;
    localparam int LOAD_LEN    = NUM_ENTRIES + 2;
    localparam int DRAIN_LEN   = 40;
    // reset, two table loads and the four runs
    localparam int TEST_CYCLES = 4 + 2 * LOAD_LEN + (12 * 20 + DRAIN_LEN)
                               + (8 * 20 + DRAIN_LEN) + (20 * 16 + DRAIN_LEN)
                               + (6 * 20 + DRAIN_LEN);
    localparam int MAX_CYCLES  = TEST_CYCLES * 3 / 2;

    logic                  clk;
    logic                  rst;
    cpu_wr_t               cpu_wr;
    logic                  stm_en;
    logic [3:0]            cycle;
    logic [15:0]           freq_div;
    gain_fmt_e             fmt;
    logic [`STM_WIDTH-1:0] ult_cycle;
    logic                  drive_ready;
    drive_t                drive;
    logic                  drive_valid;
    logic [3:0]            idx;

    logic [15:0] shadow [NUM_ENTRIES];  // host view of the table
    int          errors;
    int          words_seen;
    int          points_done;
    int          tests_run;
    int          cycle_cnt;
    int          expect_tr;
    logic [3:0]  cur_point;
    logic [3:0]  prev_point;
    bit          have_prev;
    bit          in_order;              // strict idx sequencing

    stm_operator i_stm_operator (
        .clk         (clk),
        .rst         (rst),
        .cpu_wr      (cpu_wr),
        .stm_en      (stm_en),
        .cycle       (cycle),
        .freq_div    (freq_div),
        .fmt         (fmt),
        .ult_cycle   (ult_cycle),
        .drive_ready (drive_ready),
        .drive       (drive),
        .drive_valid (drive_valid),
        .idx         (idx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // expected word from the table shadow
    function automatic drive_t expect_drive(input logic [15:0] tbl [NUM_ENTRIES],
                                            input logic [3:0] point, input int tr,
                                            input gain_fmt_e f,
                                            input logic [`STM_WIDTH-1:0] ult);
        int unsigned word;
        int unsigned duty_full;
        int unsigned phase_full;
        drive_t      w;
        word       = tbl[point * NUM_TR + tr];
        duty_full  = (word / 256) * ult;
        phase_full = (word % 256) * ult;
        w.point    = point;
        w.tr       = 3'(tr);
        w.duty     = (f == FMT_LEGACY) ? `STM_WIDTH'(duty_full / 512)
                                       : `STM_WIDTH'(duty_full / 256);
        w.phase    = `STM_WIDTH'(phase_full / 256);
        w.start    = (tr == 0);
        w.done     = (tr == NUM_TR - 1);
        return w;
    endfunction

    function automatic logic [3:0] next_point(input logic [3:0] p);
        return (p >= cycle) ? 4'd0 : p + 4'd1;
    endfunction

    task automatic check_drive(input string name, input drive_t got, input drive_t exp);
        if (got !== exp) begin
            $display("ERR %s point %h tr %h: got %h expected %h", name, exp.point, exp.tr,
                     got, exp);
            errors++;
        end
    endtask

    task automatic check_index(input string name, input logic [3:0] got,
                               input logic [3:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // sampled mid-cycle, transfer happens on the next rising edge
    always @(negedge clk) begin : compare_words
        drive_t exp_w;
        if (!rst && drive_valid && drive_ready) begin
            if (expect_tr == 0) begin
                if (in_order) begin
                    cur_point = have_prev ? next_point(prev_point) : 4'd0;
                    if (stm_en) check_index("idx", idx, cur_point);
                end else begin
                    if (drive.point > cycle || (have_prev && drive.point == prev_point)) begin
                        $display("point %0d does not move forward from point %0d",
                                 drive.point, prev_point);
                        errors++;
                    end
                    cur_point = drive.point;
                end
            end
            exp_w = expect_drive(shadow, cur_point, expect_tr, fmt, ult_cycle);
            check_drive("drive", drive, exp_w);
            words_seen++;
            if (expect_tr == NUM_TR - 1) begin
                expect_tr  = 0;
                prev_point = cur_point;
                have_prev  = 1'b1;
                points_done++;
            end else begin
                expect_tr++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout after %0d cycles, tests did not finish", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic load_table();
        logic [15:0] data;
        for (int a = 0; a < NUM_ENTRIES; a++) begin
            data      = 16'($urandom);
            cpu_wr    = '{en: 1'b1, addr: 7'(a), data: data};
            shadow[a] = data;
            step();
        end
        cpu_wr = '0;
    endtask

    task automatic run_test(input string name, input gain_fmt_e f, input logic [3:0] cyc,
                            input logic [15:0] div, input logic [`STM_WIDTH-1:0] ult,
                            input bit bp, input int n_pts);
        int err0;
        int pts0;
        int words0;
        int quiet;
        err0        = errors;
        pts0        = points_done;
        words0      = words_seen;
        expect_tr   = 0;
        have_prev   = 1'b0;
        in_order    = !bp;
        fmt         = f;
        cycle       = cyc;
        freq_div    = div;
        ult_cycle   = ult;
        drive_ready = 1'b1;
        step();
        stm_en = 1'b1;
        while (points_done - pts0 < n_pts) begin
            step();
            if (bp) drive_ready = ($urandom % 4) != 0;
        end
        stm_en      = 1'b0;
        drive_ready = 1'b1;
        quiet       = 0;
        while (quiet < 16) begin  // let the last point drain
            step();
            quiet = drive_valid ? 0 : quiet + 1;
        end
        if (expect_tr != 0) begin
            $display("point %0d stopped after %0d of %0d words", cur_point, expect_tr, NUM_TR);
            errors++;
        end
        tests_run++;
        $display("test %s: %0d points, %0d words, %0d errors", name, points_done - pts0,
                 words_seen - words0, errors - err0);
    endtask

    initial begin
        void'($urandom(90));
        rst         = 1'b1;
        cpu_wr      = '0;
        stm_en      = 1'b0;
        cycle       = 4'd0;
        freq_div    = 16'd1;
        fmt         = FMT_FULL;
        ult_cycle   = '0;
        drive_ready = 1'b1;
        errors      = 0;
        words_seen  = 0;
        points_done = 0;
        tests_run   = 0;
        cycle_cnt   = 0;
        expect_tr   = 0;
        have_prev   = 1'b0;
        in_order    = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;

        load_table();
        run_test("full_scale", FMT_FULL, 4'd7, 16'd20, 13'd5000, 1'b0, 12);
        run_test("legacy_scale", FMT_LEGACY, 4'd3, 16'd20, 13'd8191, 1'b0, 8);
        run_test("back_pressure", FMT_FULL, 4'd11, 16'd4, `STM_WIDTH'($urandom), 1'b1, 20);
        load_table();  // host rewrite between runs
        run_test("table_rewrite", FMT_FULL, 4'd4, 16'd20, 13'd4096, 1'b0, 6);

        $display("summary: %0d tests, %0d points, %0d words, %0d errors", tests_run,
                 points_done, words_seen, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
rtl/stm_data_pkg.sv
rtl/stm_ctrl_pkg.sv
rtl/stm_fetch.sv
rtl/stm_point_fifo.sv
rtl/stm_gain_operator.sv
rtl/stm_operator.sv
verification/stm_operator_properties.sv
verification/tb_stm_operator.sv

// File: Bender.yml
package:
  name: stm_operator

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/stm_data_pkg.sv
      - rtl/stm_ctrl_pkg.sv
      - rtl/stm_fetch.sv
      - rtl/stm_point_fifo.sv
      - rtl/stm_gain_operator.sv
      - rtl/stm_operator.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/stm_operator_properties.sv
      - verification/tb_stm_operator.sv
